//--- sources.f
+incdir+.
decode_pkg.sv
decode_1st.sv
decode_2nd.sv
decode_credit_ctrl.sv
decode_cfg_regs.sv
decode_top.sv
decode_tb_clk.sv
decode_sva.sv
decode_tb.sv

//--- Makefile
SRCS := $(filter %.sv,$(shell cat sources.f)) decode_defines.svh

.PHONY: all run clean

all: run

obj_dir/Vdecode_tb: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module decode_tb \
		-f sources.f -o Vdecode_tb

run: obj_dir/Vdecode_tb
	@out="$$(./obj_dir/Vdecode_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf obj_dir

//--- decode_tb.sv
`include "decode_defines.svh"

module decode_tb;

    import decode_pkg::*;

    localparam int NROWS = 10;
    localparam int CW = `DECODE_CREDIT_W;

    logic                    CLK;
    logic                    rst_n;
    logic                    flush;
    logic                    in_valid;
    logic                    in_ready;
    logic [`DECODE_XLEN-1:0] in_pc;
    logic [31:0]             in_inst;
    logic                    out_valid;
    logic [`DECODE_XLEN-1:0] out_pc;
    opcode_e                 out_opcode;
    logic [4:0]              out_rd;
    logic [4:0]              out_rs1;
    logic [4:0]              out_rs2;
    logic [2:0]              out_funct3;
    logic [6:0]              out_funct7;
    logic [`DECODE_XLEN-1:0] out_imm;
    inst_fmt_e               out_fmt;
    logic                    out_illegal;
    logic                    credit_return;
    logic                    cfg_we;
    logic                    cfg_addr;
    logic [CW-1:0]           cfg_wdata;
    logic [15:0]             cfg_rdata;

    // Stimulus and expected-value table
    logic [31:0] tab_inst [NROWS];
    logic [31:0] tab_pc   [NROWS];
    opcode_e     tab_opc  [NROWS];
    inst_fmt_e   tab_fmt  [NROWS];
    logic [31:0] tab_imm  [NROWS];
    logic        tab_ill  [NROWS];
    logic [4:0]  tab_rd   [NROWS];
    logic [4:0]  tab_rs1  [NROWS];
    logic [4:0]  tab_rs2  [NROWS];
    logic [2:0]  tab_f3   [NROWS];
    logic [6:0]  tab_f7   [NROWS];

    int          exp_q[$];
    int          errors;
    int          tests;
    int          failed_tests;
    int          test_err0;
    int          pending;
    int          ret_delay;
    logic [31:0] rng;
    logic        auto_ret;
    logic        prev_acc;
    logic        accepted;

    logic        drv_valid;
    int          drv_row;
    logic        drv_flush;
    logic        drv_ret;
    logic        drv_we;
    logic        drv_addr;
    logic [CW-1:0] drv_wdata;

    decode_tb_clk u_clk (
        .CLK   (CLK),
        .rst_n (rst_n)
    );

    decode_top u_decode_top (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .out_valid     (out_valid),
        .out_pc        (out_pc),
        .out_opcode    (out_opcode),
        .out_rd        (out_rd),
        .out_rs1       (out_rs1),
        .out_rs2       (out_rs2),
        .out_funct3    (out_funct3),
        .out_funct7    (out_funct7),
        .out_imm       (out_imm),
        .out_fmt       (out_fmt),
        .out_illegal   (out_illegal),
        .credit_return (credit_return),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata)
    );

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic add_row(input int i, input logic [31:0] inst, input logic [31:0] pc,
                           input opcode_e opc, input inst_fmt_e fmt,
                           input logic [31:0] imm, input logic ill);
        tab_inst[i] = inst;
        tab_pc[i]   = pc;
        tab_opc[i]  = opc;
        tab_fmt[i]  = fmt;
        tab_imm[i]  = imm;
        tab_ill[i]  = ill;
    endtask

    task automatic add_fields(input int i, input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic [2:0] f3,
                              input logic [6:0] f7);
        tab_rd[i]  = rd;
        tab_rs1[i] = rs1;
        tab_rs2[i] = rs2;
        tab_f3[i]  = f3;
        tab_f7[i]  = f7;
    endtask

    task automatic check_opcode(input string name, input opcode_e got, input opcode_e exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_fmt(input string name, input inst_fmt_e got, input inst_fmt_e exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_delivery();
        int idx;
        idx = exp_q.pop_front();
        check_word("out_pc", out_pc, tab_pc[idx]);
        check_opcode("out_opcode", out_opcode, tab_opc[idx]);
        check_fmt("out_fmt", out_fmt, tab_fmt[idx]);
        check_word("out_imm", out_imm, tab_imm[idx]);
        check_flag("out_illegal", out_illegal, tab_ill[idx]);
        check_word("out_rd", {27'b0, out_rd}, {27'b0, tab_rd[idx]});
        check_word("out_rs1", {27'b0, out_rs1}, {27'b0, tab_rs1[idx]});
        check_word("out_rs2", {27'b0, out_rs2}, {27'b0, tab_rs2[idx]});
        check_word("out_funct3", {29'b0, out_funct3}, {29'b0, tab_f3[idx]});
        check_word("out_funct7", {25'b0, out_funct7}, {25'b0, tab_f7[idx]});
    endtask

    // One cycle: check outputs, run the scheduler model, drive inputs
    task automatic step();
        logic ret;
        @(negedge CLK);
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected out_valid with nothing in flight at %0t", $time);
            end else begin
                check_delivery();
            end
            pending++;
        end
        ret = drv_ret;
        if (auto_ret && pending > 0) begin
            if (ret_delay == 0) begin
                ret       = 1'b1;
                ret_delay = int'(xorshift32() % 3);
            end else begin
                ret_delay--;
            end
        end
        if (ret && pending > 0) begin
            pending--;
        end
        credit_return = ret;
        // Instruction in stage 1 is lost on a flush
        if (drv_flush && prev_acc) begin
            exp_q.delete(exp_q.size() - 1);
        end
        flush     = drv_flush;
        in_valid  = drv_valid;
        in_pc     = tab_pc[drv_row];
        in_inst   = tab_inst[drv_row];
        cfg_we    = drv_we;
        cfg_addr  = drv_addr;
        cfg_wdata = drv_wdata;
        #1;
        accepted = drv_valid && in_ready;
        if (accepted) begin
            exp_q.push_back(drv_row);
        end
        prev_acc = accepted;
    endtask

    task automatic send_row(input int row);
        int n;
        n         = 0;
        drv_valid = 1'b1;
        drv_row   = row;
        accepted  = 1'b0;
        while (!accepted && n < 40) begin
            step();
            n++;
        end
        drv_valid = 1'b0;
        if (!accepted) begin
            errors++;
            $display("Timeout: row %0d was never accepted", row);
        end
    endtask

    task automatic count_accepts(input int cycles, output int count);
        count = 0;
        for (int i = 0; i < cycles; i++) begin
            drv_valid = 1'b1;
            drv_row   = i % 6;
            step();
            if (accepted) begin
                count++;
            end
        end
        drv_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n         = 0;
        auto_ret  = 1'b1;
        drv_valid = 1'b0;
        while ((exp_q.size() > 0 || pending > 0) && n < 200) begin
            step();
            n++;
        end
        if (exp_q.size() > 0 || pending > 0) begin
            errors++;
            $display("Timeout while waiting for outstanding instructions and credits");
        end
    endtask

    task automatic cfg_write(input logic addr, input logic [CW-1:0] data);
        drv_we    = 1'b1;
        drv_addr  = addr;
        drv_wdata = data;
        step();
        drv_we    = 1'b0;
    endtask

    task automatic cfg_read(input logic addr, input logic [31:0] exp, input string name);
        drv_addr = addr;
        step();
        check_word(name, {16'b0, cfg_rdata}, exp);
    endtask

    task automatic begin_test();
        test_err0 = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_err0) begin
            $display("Test %0d %s: passed", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed with %0d errors", tests, name, errors - test_err0);
        end
    endtask

    initial begin
        #400000;
        $display("Simulation time limit reached");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int n;
        int cnt;
        flush = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_inst = '0;
        credit_return = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = 1'b0;
        cfg_wdata = '0;
        drv_valid = 1'b0;
        drv_row = 0;
        drv_flush = 1'b0;
        drv_ret = 1'b0;
        drv_we = 1'b0;
        drv_addr = 1'b0;
        drv_wdata = '0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        pending = 0;
        ret_delay = 0;
        rng = 32'd38;
        auto_ret = 1'b1;
        prev_acc = 1'b0;
        accepted = 1'b0;

        // R, I, S, B, U, J, two illegal opcodes, load, auipc
        add_row(0, 32'h002081b3, 32'h00001000, OPC_OP, FMT_R, 32'h00000000, 1'b0);
        add_row(1, 32'hfff30293, 32'h00001004, OPC_OP_IMM, FMT_I, 32'hffffffff, 1'b0);
        add_row(2, 32'h00712423, 32'h00001008, OPC_STORE, FMT_S, 32'h00000008, 1'b0);
        add_row(3, 32'hfe008ee3, 32'h0000100c, OPC_BRANCH, FMT_B, 32'hfffffffc, 1'b0);
        add_row(4, 32'h12345537, 32'h00001010, OPC_LUI, FMT_U, 32'h12345000, 1'b0);
        add_row(5, 32'h0010006f, 32'h00001014, OPC_JAL, FMT_J, 32'h00000800, 1'b0);
        add_row(6, 32'h0000017f, 32'h00001018, opcode_e'(7'h7f), FMT_NONE, 32'h0, 1'b1);
        add_row(7, 32'h8000000b, 32'h0000101c, opcode_e'(7'h0b), FMT_NONE, 32'h0, 1'b1);
        add_row(8, 32'h8001a203, 32'h00001020, OPC_LOAD, FMT_I, 32'hfffff800, 1'b0);
        add_row(9, 32'hfffff117, 32'h00001024, OPC_AUIPC, FMT_U, 32'hfffff000, 1'b0);

        // rd, rs1, rs2, funct3, funct7 per row
        add_fields(0, 5'd3, 5'd1, 5'd2, 3'd0, 7'h00);
        add_fields(1, 5'd5, 5'd6, 5'd31, 3'd0, 7'h7f);
        add_fields(2, 5'd8, 5'd2, 5'd7, 3'd2, 7'h00);
        add_fields(3, 5'd29, 5'd1, 5'd0, 3'd0, 7'h7f);
        add_fields(4, 5'd10, 5'd8, 5'd3, 3'd5, 7'h09);
        add_fields(5, 5'd0, 5'd0, 5'd1, 3'd0, 7'h00);
        add_fields(6, 5'd2, 5'd0, 5'd0, 3'd0, 7'h00);
        add_fields(7, 5'd0, 5'd0, 5'd0, 3'd0, 7'h40);
        add_fields(8, 5'd4, 5'd3, 5'd0, 3'd2, 7'h40);
        add_fields(9, 5'd2, 5'd31, 5'd31, 3'd7, 7'h7f);

        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(negedge CLK);
            n++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("Reset was never released");
        end

        begin_test();
        for (int i = 0; i < NROWS; i++) begin
            if (!tab_ill[i]) begin
                send_row(i);
            end
        end
        drain();
        end_test("formats and immediates");

        begin_test();
        send_row(6);
        send_row(7);
        drain();
        cfg_read(`DECODE_CFG_ILLEGAL, 32'd2, "cfg_rdata");
        cfg_write(`DECODE_CFG_ILLEGAL, '0);
        cfg_read(`DECODE_CFG_ILLEGAL, 32'd0, "cfg_rdata");
        end_test("illegal opcode");

        begin_test();
        auto_ret = 1'b0;
        count_accepts(12, cnt);
        check_word("accepted count", cnt, `DECODE_CREDITS_RST);
        for (int k = 0; k < 2; k++) begin
            drv_ret = 1'b1;
            step();
            drv_ret = 1'b0;
            count_accepts(6, cnt);
            check_word("accepted after return", cnt, 32'd1);
        end
        drain();
        end_test("credit back-pressure");

        begin_test();
        for (int i = 0; i < NROWS; i++) begin
            send_row(i);
        end
        drain();
        end_test("ordering and overlap");

        begin_test();
        send_row(2);
        drv_flush = 1'b1;
        step();
        drv_flush = 1'b0;
        repeat (5) step();
        drain();
        auto_ret = 1'b0;
        count_accepts(12, cnt);
        check_word("accepted after flush", cnt, `DECODE_CREDITS_RST);
        drain();
        end_test("flush");

        begin_test();
        cfg_write(`DECODE_CFG_LIMIT, CW'(2));
        step();
        auto_ret = 1'b0;
        count_accepts(10, cnt);
        check_word("accepted with limit 2", cnt, 32'd2);
        cfg_read(`DECODE_CFG_LIMIT, 32'd2, "cfg_rdata");
        drain();
        end_test("limit write");

        $display("Tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- decode_sva.sv
`include "decode_defines.svh"

module decode_sva (
    input logic                     CLK,
    input logic                     rst_n,
    input logic                     flush,
    input logic                     in_valid,
    input logic                     in_ready,
    input logic                     out_valid,
    input logic                     out_illegal,
    input decode_pkg::inst_fmt_e    out_fmt,
    input logic [`DECODE_XLEN-1:0]  out_imm
);

    import decode_pkg::*;

    a_ready_low_on_flush: assert property (
        @(posedge CLK) disable iff (!rst_n) flush |-> !in_ready
    ) else $error("in_ready high during a flush cycle");

    a_illegal_fmt_none: assert property (
        @(posedge CLK) disable iff (!rst_n) out_illegal |-> (out_fmt == FMT_NONE)
    ) else $error("out_illegal set with a format other than FMT_NONE");

    // Two-cycle latency unless a flush hits the first stage
    a_fixed_latency: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (in_valid && in_ready) |=> (flush or (##1 out_valid))
    ) else $error("accepted instruction did not reach out_valid two cycles later");

    a_r_fmt_zero_imm: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (out_valid && (out_fmt == FMT_R)) |-> (out_imm == '0)
    ) else $error("R format delivered with a nonzero immediate");

endmodule

bind decode_top decode_sva u_decode_sva (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .flush       (flush),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_illegal (out_illegal),
    .out_fmt     (out_fmt),
    .out_imm     (out_imm)
);

//--- decode_tb_clk.sv
module decode_tb_clk (
    output logic CLK,
    output logic rst_n
);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Reset held for two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
    end

endmodule

//--- decode_top.sv
`include "decode_defines.svh"

module decode_top (
    input  logic                         CLK,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic [`DECODE_XLEN-1:0]      in_pc,
    input  logic [31:0]                  in_inst,
    output logic                         out_valid,
    output logic [`DECODE_XLEN-1:0]      out_pc,
    output decode_pkg::opcode_e          out_opcode,
    output logic [4:0]                   out_rd,
    output logic [4:0]                   out_rs1,
    output logic [4:0]                   out_rs2,
    output logic [2:0]                   out_funct3,
    output logic [6:0]                   out_funct7,
    output logic [`DECODE_XLEN-1:0]      out_imm,
    output decode_pkg::inst_fmt_e        out_fmt,
    output logic                         out_illegal,
    input  logic                         credit_return,
    input  logic                         cfg_we,
    input  logic                         cfg_addr,
    input  logic [`DECODE_CREDIT_W-1:0]  cfg_wdata,
    output logic [15:0]                  cfg_rdata
);

    import decode_pkg::*;

    logic                        s1_valid;
    logic [`DECODE_XLEN-1:0]     s1_pc;
    opcode_e                     s1_opcode;
    logic [4:0]                  s1_rd;
    logic [4:0]                  s1_rs1;
    logic [4:0]                  s1_rs2;
    logic [2:0]                  s1_funct3;
    logic [6:0]                  s1_funct7;
    logic [`DECODE_XLEN-1:0]     s1_imm_i;
    logic [`DECODE_XLEN-1:0]     s1_imm_s;
    logic [`DECODE_XLEN-1:0]     s1_imm_b;
    logic [`DECODE_XLEN-1:0]     s1_imm_u;
    logic [`DECODE_XLEN-1:0]     s1_imm_j;
    logic [`DECODE_CREDIT_W-1:0] credit_limit;
    logic                        limit_load;

    decode_1st u_decode_1st (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pc     (in_pc),
        .in_inst   (in_inst),
        .s1_valid  (s1_valid),
        .s1_pc     (s1_pc),
        .s1_opcode (s1_opcode),
        .s1_rd     (s1_rd),
        .s1_rs1    (s1_rs1),
        .s1_rs2    (s1_rs2),
        .s1_funct3 (s1_funct3),
        .s1_funct7 (s1_funct7),
        .s1_imm_i  (s1_imm_i),
        .s1_imm_s  (s1_imm_s),
        .s1_imm_b  (s1_imm_b),
        .s1_imm_u  (s1_imm_u),
        .s1_imm_j  (s1_imm_j)
    );

    decode_2nd u_decode_2nd (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .flush       (flush),
        .s1_valid    (s1_valid),
        .s1_pc       (s1_pc),
        .s1_opcode   (s1_opcode),
        .s1_rd       (s1_rd),
        .s1_rs1      (s1_rs1),
        .s1_rs2      (s1_rs2),
        .s1_funct3   (s1_funct3),
        .s1_funct7   (s1_funct7),
        .s1_imm_i    (s1_imm_i),
        .s1_imm_s    (s1_imm_s),
        .s1_imm_b    (s1_imm_b),
        .s1_imm_u    (s1_imm_u),
        .s1_imm_j    (s1_imm_j),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_opcode  (out_opcode),
        .out_rd      (out_rd),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_funct3  (out_funct3),
        .out_funct7  (out_funct7),
        .out_imm     (out_imm),
        .out_fmt     (out_fmt),
        .out_illegal (out_illegal)
    );

    decode_credit_ctrl u_credit_ctrl (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .flush         (flush),
        .in_valid      (in_valid),
        .s1_valid      (s1_valid),
        .credit_return (credit_return),
        .limit_load    (limit_load),
        .credit_limit  (credit_limit),
        .in_ready      (in_ready)
    );

    decode_cfg_regs u_cfg_regs (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .out_valid    (out_valid),
        .out_illegal  (out_illegal),
        .cfg_rdata    (cfg_rdata),
        .credit_limit (credit_limit),
        .limit_load   (limit_load)
    );

endmodule

//--- decode_cfg_regs.sv
`include "decode_defines.svh"

module decode_cfg_regs (
    input  logic                         CLK,
    input  logic                         rst_n,
    input  logic                         cfg_we,
    input  logic                         cfg_addr,
    input  logic [`DECODE_CREDIT_W-1:0]  cfg_wdata,
    input  logic                         out_valid,
    input  logic                         out_illegal,
    output logic [15:0]                  cfg_rdata,
    output logic [`DECODE_CREDIT_W-1:0]  credit_limit,
    output logic                         limit_load
);

    localparam int CW = `DECODE_CREDIT_W;

    logic [15:0] illegal_cnt;
    logic        wr_limit;
    logic        wr_illegal;

    assign wr_limit   = cfg_we && (cfg_addr == `DECODE_CFG_LIMIT);
    assign wr_illegal = cfg_we && (cfg_addr == `DECODE_CFG_ILLEGAL);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            credit_limit <= CW'(`DECODE_CREDITS_RST);
            limit_load   <= 1'b0;
        end else begin
            if (wr_limit) begin
                credit_limit <= cfg_wdata;
            end
            // Credit counter reloads one edge after the write
            limit_load <= wr_limit;
        end
    end

    // Saturating count of delivered illegal instructions
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            illegal_cnt <= '0;
        end else if (wr_illegal) begin
            illegal_cnt <= '0;
        end else if (out_valid && out_illegal && (illegal_cnt != 16'hffff)) begin
            illegal_cnt <= illegal_cnt + 16'd1;
        end
    end

    always_comb begin
        if (cfg_addr == `DECODE_CFG_LIMIT) begin
            cfg_rdata = {{(16-CW){1'b0}}, credit_limit};
        end else begin
            cfg_rdata = illegal_cnt;
        end
    end

endmodule

//--- decode_credit_ctrl.sv
`include "decode_defines.svh"

module decode_credit_ctrl (
    input  logic                         CLK,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         in_valid,
    input  logic                         s1_valid,
    input  logic                         credit_return,
    input  logic                         limit_load,
    input  logic [`DECODE_CREDIT_W-1:0]  credit_limit,
    output logic                         in_ready
);

    localparam int CW = `DECODE_CREDIT_W;

    logic [CW-1:0] credit_cnt;
    logic [CW-1:0] credit_nxt;
    logic          accept;
    logic          recover;

    // No acceptance can happen in a flush cycle
    assign in_ready = (credit_cnt != '0) && !flush;
    assign accept   = in_valid && in_ready;

    // Instruction dropped from stage 1 gives its entry back
    assign recover  = flush && s1_valid;

    always_comb begin
        credit_nxt = credit_cnt
                   + CW'(credit_return)
                   + CW'(recover)
                   - CW'(accept);
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CW'(`DECODE_CREDITS_RST);
        end else if (limit_load) begin
            // Only written while idle with nothing outstanding
            credit_cnt <= credit_limit;
        end else begin
            credit_cnt <= credit_nxt;
        end
    end

endmodule

//--- decode_2nd.sv
`include "decode_defines.svh"

module decode_2nd (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      s1_valid,
    input  logic [`DECODE_XLEN-1:0]   s1_pc,
    input  decode_pkg::opcode_e       s1_opcode,
    input  logic [4:0]                s1_rd,
    input  logic [4:0]                s1_rs1,
    input  logic [4:0]                s1_rs2,
    input  logic [2:0]                s1_funct3,
    input  logic [6:0]                s1_funct7,
    input  logic [`DECODE_XLEN-1:0]   s1_imm_i,
    input  logic [`DECODE_XLEN-1:0]   s1_imm_s,
    input  logic [`DECODE_XLEN-1:0]   s1_imm_b,
    input  logic [`DECODE_XLEN-1:0]   s1_imm_u,
    input  logic [`DECODE_XLEN-1:0]   s1_imm_j,
    output logic                      out_valid,
    output logic [`DECODE_XLEN-1:0]   out_pc,
    output decode_pkg::opcode_e       out_opcode,
    output logic [4:0]                out_rd,
    output logic [4:0]                out_rs1,
    output logic [4:0]                out_rs2,
    output logic [2:0]                out_funct3,
    output logic [6:0]                out_funct7,
    output logic [`DECODE_XLEN-1:0]   out_imm,
    output decode_pkg::inst_fmt_e     out_fmt,
    output logic                      out_illegal
);

    import decode_pkg::*;

    inst_fmt_e               fmt;
    logic [`DECODE_XLEN-1:0] imm_sel;

    // Opcode class to format
    always_comb begin
        case (s1_opcode)
            OPC_OP:       fmt = FMT_R;
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM,
            OPC_MISC_MEM,
            OPC_SYSTEM:   fmt = FMT_I;
            OPC_STORE:    fmt = FMT_S;
            OPC_BRANCH:   fmt = FMT_B;
            OPC_LUI,
            OPC_AUIPC:    fmt = FMT_U;
            OPC_JAL:      fmt = FMT_J;
            default:      fmt = FMT_NONE;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I:   imm_sel = s1_imm_i;
            FMT_S:   imm_sel = s1_imm_s;
            FMT_B:   imm_sel = s1_imm_b;
            FMT_U:   imm_sel = s1_imm_u;
            FMT_J:   imm_sel = s1_imm_j;
            // R and unsupported carry no immediate
            default: imm_sel = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            out_illegal <= 1'b0;
        end else if (flush) begin
            out_valid   <= 1'b0;
            out_illegal <= 1'b0;
        end else begin
            out_valid   <= s1_valid;
            out_illegal <= s1_valid && (fmt == FMT_NONE);
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            out_pc     <= '0;
            out_opcode <= opcode_e'(7'b0);
            out_rd     <= '0;
            out_rs1    <= '0;
            out_rs2    <= '0;
            out_funct3 <= '0;
            out_funct7 <= '0;
            out_imm    <= '0;
            out_fmt    <= FMT_R;
        end else if (flush) begin
            out_pc     <= '0;
            out_opcode <= opcode_e'(7'b0);
            out_rd     <= '0;
            out_rs1    <= '0;
            out_rs2    <= '0;
            out_funct3 <= '0;
            out_funct7 <= '0;
            out_imm    <= '0;
            out_fmt    <= FMT_R;
        end else if (s1_valid) begin
            out_pc     <= s1_pc;
            out_opcode <= s1_opcode;
            out_rd     <= s1_rd;
            out_rs1    <= s1_rs1;
            out_rs2    <= s1_rs2;
            out_funct3 <= s1_funct3;
            out_funct7 <= s1_funct7;
            out_imm    <= imm_sel;
            out_fmt    <= fmt;
        end
    end

endmodule

//--- decode_1st.sv
`include "decode_defines.svh"

module decode_1st (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      in_valid,
    input  logic                      in_ready,
    input  logic [`DECODE_XLEN-1:0]   in_pc,
    input  logic [31:0]               in_inst,
    output logic                      s1_valid,
    output logic [`DECODE_XLEN-1:0]   s1_pc,
    output decode_pkg::opcode_e       s1_opcode,
    output logic [4:0]                s1_rd,
    output logic [4:0]                s1_rs1,
    output logic [4:0]                s1_rs2,
    output logic [2:0]                s1_funct3,
    output logic [6:0]                s1_funct7,
    output logic [`DECODE_XLEN-1:0]   s1_imm_i,
    output logic [`DECODE_XLEN-1:0]   s1_imm_s,
    output logic [`DECODE_XLEN-1:0]   s1_imm_b,
    output logic [`DECODE_XLEN-1:0]   s1_imm_u,
    output logic [`DECODE_XLEN-1:0]   s1_imm_j
);

    import decode_pkg::*;

    logic                    accept;
    logic [`DECODE_XLEN-1:0] imm_i;
    logic [`DECODE_XLEN-1:0] imm_s;
    logic [`DECODE_XLEN-1:0] imm_b;
    logic [`DECODE_XLEN-1:0] imm_u;
    logic [`DECODE_XLEN-1:0] imm_j;

    assign accept = in_valid && in_ready;

    // Candidate immediates, sign bit is always inst[31]
    assign imm_i = {{(`DECODE_XLEN-12){in_inst[31]}}, in_inst[31:20]};
    assign imm_s = {{(`DECODE_XLEN-12){in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
    assign imm_b = {{(`DECODE_XLEN-13){in_inst[31]}}, in_inst[31], in_inst[7],
                    in_inst[30:25], in_inst[11:8], 1'b0};
    assign imm_u = {{(`DECODE_XLEN-32){in_inst[31]}}, in_inst[31:12], 12'b0};
    assign imm_j = {{(`DECODE_XLEN-21){in_inst[31]}}, in_inst[31], in_inst[19:12],
                    in_inst[20], in_inst[30:21], 1'b0};

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (flush) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            s1_pc     <= '0;
            s1_opcode <= opcode_e'(7'b0);
            s1_rd     <= '0;
            s1_rs1    <= '0;
            s1_rs2    <= '0;
            s1_funct3 <= '0;
            s1_funct7 <= '0;
            s1_imm_i  <= '0;
            s1_imm_s  <= '0;
            s1_imm_b  <= '0;
            s1_imm_u  <= '0;
            s1_imm_j  <= '0;
        end else if (flush) begin
            s1_pc     <= '0;
            s1_opcode <= opcode_e'(7'b0);
            s1_rd     <= '0;
            s1_rs1    <= '0;
            s1_rs2    <= '0;
            s1_funct3 <= '0;
            s1_funct7 <= '0;
            s1_imm_i  <= '0;
            s1_imm_s  <= '0;
            s1_imm_b  <= '0;
            s1_imm_u  <= '0;
            s1_imm_j  <= '0;
        end else if (accept) begin
            s1_pc     <= in_pc;
            s1_opcode <= opcode_e'(in_inst[6:0]);
            s1_rd     <= in_inst[11:7];
            s1_rs1    <= in_inst[19:15];
            s1_rs2    <= in_inst[24:20];
            s1_funct3 <= in_inst[14:12];
            s1_funct7 <= in_inst[31:25];
            s1_imm_i  <= imm_i;
            s1_imm_s  <= imm_s;
            s1_imm_b  <= imm_b;
            s1_imm_u  <= imm_u;
            s1_imm_j  <= imm_j;
        end
    end

endmodule

//--- decode_pkg.sv
package decode_pkg;

    // RV32I major opcodes, standard encodings
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // Instruction formats
    typedef enum logic [2:0] {
        FMT_R    = 3'd0,
        FMT_I    = 3'd1,
        FMT_S    = 3'd2,
        FMT_B    = 3'd3,
        FMT_U    = 3'd4,
        FMT_J    = 3'd5,
        // Opcode not supported
        FMT_NONE = 3'd6
    } inst_fmt_e;

endpackage

//--- decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Datapath width for PC, instruction and immediate
`define DECODE_XLEN 32

// Credit counter and credit limit width
`define DECODE_CREDIT_W 4

// Scheduler entries after reset
`define DECODE_CREDITS_RST 4

// Configuration register map
`define DECODE_CFG_LIMIT 1'b0
`define DECODE_CFG_ILLEGAL 1'b1

`endif
